/* rtl/board_pkg.sv */
package board_pkg;

    // playfield size
    localparam int board_rows = 20;
    localparam int board_cols = 10;

    // one bit per cell, first index is the row, row 0 at the top
    typedef logic [board_rows-1:0][board_cols-1:0] board_t;

    // row of the piece's top edge
    typedef logic [4:0] row_t;

    // fall controller states
    typedef enum logic [2:0] {
        st_idle  = 3'd0,
        st_spawn = 3'd1,
        st_check = 3'd2,
        st_fall  = 3'd3,
        st_lock  = 3'd4,
        st_over  = 3'd5
    } fall_state_t;

endpackage

/* rtl/piece_pkg.sv */
package piece_pkg;

    typedef enum logic [2:0] {
        pk_line   = 3'd0,
        pk_square = 3'd1,
        pk_l      = 3'd2,
        pk_rev_l  = 3'd3,
        pk_s      = 3'd4,
        pk_z      = 3'd5,
        pk_t      = 3'd6,
        pk_none   = 3'd7
    } piece_kind_t;

    // each cell is {row offset[1:0], column[3:0]}
    // row offset counts down from the piece's top row
    localparam logic [5:0] piece_cells [7][4] = '{
        // line
        '{{2'd0, 4'd4}, {2'd1, 4'd4}, {2'd2, 4'd4}, {2'd3, 4'd4}},
        // square
        '{{2'd0, 4'd4}, {2'd0, 4'd5}, {2'd1, 4'd4}, {2'd1, 4'd5}},
        // L
        '{{2'd0, 4'd4}, {2'd1, 4'd4}, {2'd2, 4'd4}, {2'd2, 4'd5}},
        // reverse L
        '{{2'd0, 4'd5}, {2'd1, 4'd5}, {2'd2, 4'd5}, {2'd2, 4'd4}},
        // S
        '{{2'd0, 4'd5}, {2'd0, 4'd6}, {2'd1, 4'd4}, {2'd1, 4'd5}},
        // Z
        '{{2'd0, 4'd4}, {2'd0, 4'd5}, {2'd1, 4'd5}, {2'd1, 4'd6}},
        // T
        '{{2'd0, 4'd4}, {2'd1, 4'd3}, {2'd1, 4'd4}, {2'd1, 4'd5}}
    };

    // rows spanned by each kind
    localparam logic [2:0] piece_height [7] = '{
        3'd4,
        3'd2,
        3'd3,
        3'd3,
        3'd2,
        3'd2,
        3'd2
    };

endpackage

/* rtl/fall_if.sv */
`timescale 1ns/1ps

interface fall_if
    import board_pkg::*;
();

    // piece cells now and one row lower
    board_t cur_mask;
    board_t next_mask;
    logic   bottom_hit;

    // results from the settled board
    logic   blocked;
    logic   overlap;

    modport mover_side (
        output cur_mask,
        output next_mask,
        output bottom_hit
    );

    modport board_side (
        input  cur_mask,
        input  next_mask,
        input  bottom_hit,
        output blocked,
        output overlap
    );

    modport ctrl_side (
        input blocked,
        input overlap
    );

endinterface

/* rtl/drop_timer.sv */
`timescale 1ns/1ps

module drop_timer #(
    parameter int drop_ticks = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic restart,
    output logic tick
);

    localparam int cnt_w = (drop_ticks > 1) ? $clog2(drop_ticks) : 1;
    localparam logic [cnt_w-1:0] reload = cnt_w'(drop_ticks - 1);

    logic [cnt_w-1:0] count;

    // free-running down-counter, reloaded on restart and on wrap
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            count <= reload;
        end else if (restart || count == '0) begin
            count <= reload;
        end else begin
            count <= count - 1'b1;
        end
    end

    // one cycle at the bottom of each interval
    assign tick = (count == '0);

endmodule

/* rtl/fall_fsm.sv */
`timescale 1ns/1ps

module fall_fsm
    import board_pkg::*;
    import piece_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  piece_kind_t      piece_kind,
    input  logic             tick,
    fall_if.ctrl_side        ctrl,
    output logic             spawn,
    output logic             step,
    output logic             lock,
    output logic             timer_restart,
    output logic             busy,
    output logic             landed,
    output logic             game_over
);

    fall_state_t state;
    fall_state_t state_next;
    logic        start_ok;

    // only a start seen in idle with a real kind is taken
    assign start_ok = start && (piece_kind != pk_none);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (start_ok) begin
                    state_next = st_spawn;
                end
            end
            st_spawn: begin
                state_next = st_check;
            end
            st_check: begin
                // new piece already sits on settled cells
                if (ctrl.overlap) begin
                    state_next = st_over;
                end else begin
                    state_next = st_fall;
                end
            end
            st_fall: begin
                if (tick && ctrl.blocked) begin
                    state_next = st_lock;
                end
            end
            st_lock: begin
                state_next = st_idle;
            end
            st_over: begin
                state_next = st_over;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    // piece is loaded on the edge into st_spawn
    assign spawn         = (state == st_idle) && start_ok;
    assign timer_restart = (state == st_spawn);
    assign step          = (state == st_fall) && tick && !ctrl.blocked;
    assign lock          = (state == st_lock);
    assign landed        = (state == st_lock);
    assign game_over     = (state == st_over);
    assign busy          = (state != st_idle) && (state != st_over);

endmodule

/* rtl/piece_mover.sv */
`timescale 1ns/1ps

module piece_mover
    import board_pkg::*;
    import piece_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        spawn,
    input  logic        step,
    input  piece_kind_t piece_kind,
    fall_if.mover_side  mv
);

    piece_kind_t kind;
    row_t        row;
    logic        has_piece;
    logic [5:0]  span_end;

    // kind and top row of the falling piece
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            kind      <= pk_line;
            row       <= '0;
            has_piece <= 1'b0;
        end else if (spawn) begin
            kind      <= piece_kind;
            row       <= '0;
            has_piece <= 1'b1;
        end else if (step) begin
            row <= row + 1'b1;
        end
    end

    // cells at the current row and one row lower
    always_comb begin : draw_masks
        logic [5:0] cur_row;
        logic [5:0] low_row;
        logic [3:0] cell_col;

        mv.cur_mask  = '0;
        mv.next_mask = '0;
        cur_row      = '0;
        low_row      = '0;
        cell_col     = '0;

        if (has_piece) begin
            for (int i = 0; i < 4; i++) begin
                cur_row  = {1'b0, row} + {4'd0, piece_cells[kind][i][5:4]};
                low_row  = cur_row + 6'd1;
                cell_col = piece_cells[kind][i][3:0];

                // cells below the floor are left out
                if (cur_row < 6'(board_rows)) begin
                    mv.cur_mask[cur_row[4:0]][cell_col] = 1'b1;
                end
                if (low_row < 6'(board_rows)) begin
                    mv.next_mask[low_row[4:0]][cell_col] = 1'b1;
                end
            end
        end
    end

    // one past the lowest occupied row
    assign span_end = {1'b0, row} + {3'd0, piece_height[kind]};

    // next row would push the piece through the floor
    assign mv.bottom_hit = has_piece && (span_end >= 6'(board_rows));

endmodule

/* rtl/board_store.sv */
`timescale 1ns/1ps

module board_store
    import board_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       lock,
    fall_if.board_side bd,
    output board_t     board_view
);

    board_t                settled;
    logic [board_rows-1:0] next_row_hit;
    logic [board_rows-1:0] cur_row_hit;

    // settled cells, piece merged in at the end of st_lock
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            settled <= '0;
        end else if (lock) begin
            settled <= settled | bd.cur_mask;
        end
    end

    // per-row collision flags
    always_comb begin
        for (int r = 0; r < board_rows; r++) begin
            next_row_hit[r] = |(settled[r] & bd.next_mask[r]);
            cur_row_hit[r]  = |(settled[r] & bd.cur_mask[r]);
        end
    end

    // floor or a settled cell under the piece
    assign bd.blocked = bd.bottom_hit || (|next_row_hit);

    // spawn landed on top of the stack
    assign bd.overlap = |cur_row_hit;

    // falling piece drawn over the stack
    assign board_view = settled | bd.cur_mask;

endmodule

/* rtl/tetris_fall_top.sv */
`timescale 1ns/1ps

module tetris_fall_top
    import board_pkg::*;
    import piece_pkg::*;
#(
    parameter int drop_ticks = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  piece_kind_t piece_kind,
    output board_t      board_view,
    output logic        busy,
    output logic        landed,
    output logic        game_over
);

    logic spawn;
    logic step;
    logic lock;
    logic timer_restart;
    logic tick;

    // masks and collision results
    fall_if fall_bus ();

    drop_timer #(
        .drop_ticks(drop_ticks)
    ) drop_timer_inst (
        .clk     (clk),
        .rst     (rst),
        .restart (timer_restart),
        .tick    (tick)
    );

    fall_fsm fall_fsm_inst (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .piece_kind    (piece_kind),
        .tick          (tick),
        .ctrl          (fall_bus),
        .spawn         (spawn),
        .step          (step),
        .lock          (lock),
        .timer_restart (timer_restart),
        .busy          (busy),
        .landed        (landed),
        .game_over     (game_over)
    );

    piece_mover piece_mover_inst (
        .clk        (clk),
        .rst        (rst),
        .spawn      (spawn),
        .step       (step),
        .piece_kind (piece_kind),
        .mv         (fall_bus)
    );

    board_store board_store_inst (
        .clk        (clk),
        .rst        (rst),
        .lock       (lock),
        .bd         (fall_bus),
        .board_view (board_view)
    );

endmodule

/* testbench/tb_checks.svh */
`ifndef tb_checks_svh
`define tb_checks_svh

// cell offsets {row, column} per kind
// rows count down from the top edge
int shape_tab [7][4][2] = '{
    '{'{0, 4}, '{1, 4}, '{2, 4}, '{3, 4}},
    '{'{0, 4}, '{0, 5}, '{1, 4}, '{1, 5}},
    '{'{0, 4}, '{1, 4}, '{2, 4}, '{2, 5}},
    '{'{0, 5}, '{1, 5}, '{2, 5}, '{2, 4}},
    '{'{0, 5}, '{0, 6}, '{1, 4}, '{1, 5}},
    '{'{0, 4}, '{0, 5}, '{1, 5}, '{1, 6}},
    '{'{0, 4}, '{1, 3}, '{1, 4}, '{1, 5}}
};

// piece cells with the top edge at row top
// cells past the floor are dropped
function automatic board_t place_shape(input piece_kind_t k, input int top);
    board_t m;
    int     r;
    m = '0;
    for (int i = 0; i < 4; i++) begin
        r = top + shape_tab[k][i][0];
        if (r < board_rows) begin
            m[r][shape_tab[k][i][1]] = 1'b1;
        end
    end
    return m;
endfunction

// piece fits when every cell is on the board and free
function automatic bit shape_fits(input piece_kind_t k, input int top);
    int r;
    int c;
    for (int i = 0; i < 4; i++) begin
        r = top + shape_tab[k][i][0];
        c = shape_tab[k][i][1];
        if (r >= board_rows) begin
            return 1'b0;
        end
        if (model_board[r][c]) begin
            return 1'b0;
        end
    end
    return 1'b1;
endfunction

// piece rests at the highest row whose next row is blocked
task automatic model_drop(input piece_kind_t k, output bit over);
    int top;
    top  = 0;
    over = !shape_fits(k, 0);
    if (!over) begin
        while (shape_fits(k, top + 1)) begin
            top++;
        end
        model_board = model_board | place_shape(k, top);
    end
endtask

task automatic check_board(input string what, input board_t got, input board_t exp);
    if (got !== exp) begin
        error_count++;
        $display("error at %0t: %s, board_view %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
        error_count++;
        $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic apply_reset();
    @(posedge clk);
    rst        <= 1'b1;
    start      <= 1'b0;
    piece_kind <= pk_none;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    model_board = '0;
endtask

// one-cycle start strobe
task automatic pulse_start(input piece_kind_t k);
    @(posedge clk);
    start      <= 1'b1;
    piece_kind <= k;
    @(posedge clk);
    start <= 1'b0;
endtask

// busy must hold until landed or game over shows up
task automatic wait_fall_end(input piece_kind_t k, input bit exp_over);
    int n;
    for (n = 0; n < land_limit; n++) begin
        @(negedge clk);
        if (landed || game_over) begin
            break;
        end
        check_bit("busy during fall", busy, 1'b1);
    end
    if (!landed && !game_over) begin
        error_count++;
        $display("kind %s: neither landed nor game over was seen within %0d cycles",
                 k.name(), land_limit);
    end else begin
        check_bit("game_over at end of fall", game_over, exp_over);
        check_bit("landed at end of fall", landed, !exp_over);
    end
endtask

task automatic drop_and_check(input piece_kind_t k);
    bit     exp_over;
    board_t exp_view;
    model_drop(k, exp_over);
    exp_view = model_board;
    // overlapping spawn stays drawn on top of the stack
    if (exp_over) begin
        exp_view = model_board | place_shape(k, 0);
    end
    pulse_start(k);
    wait_fall_end(k, exp_over);
    @(negedge clk);
    check_board($sformatf("after drop of %s", k.name()), board_view, exp_view);
    check_bit("busy after drop", busy, 1'b0);
    check_bit("landed after drop", landed, 1'b0);
endtask

task automatic end_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before) begin
        $display("test %s: ok", name);
    end else begin
        failed_tests++;
        $display("test %s: %0d errors", name, error_count - errors_before);
    end
endtask

task automatic test_reset();
    int errs;
    errs = error_count;
    apply_reset();
    @(negedge clk);
    check_board("after reset", board_view, '0);
    check_bit("busy after reset", busy, 1'b0);
    check_bit("landed after reset", landed, 1'b0);
    check_bit("game_over after reset", game_over, 1'b0);
    end_test("reset", errs);
endtask

task automatic test_single_drops();
    int errs;
    errs = error_count;
    for (int k = 0; k < 7; k++) begin
        apply_reset();
        drop_and_check(piece_kind_t'(k[2:0]));
        check_bit("cells in row 19", |board_view[board_rows-1], 1'b1);
    end
    end_test("single drops", errs);
endtask

task automatic test_stacking();
    int          errs;
    int          rnd;
    piece_kind_t k;
    errs = error_count;
    apply_reset();
    drop_and_check(pk_square);
    drop_and_check(pk_square);
    check_board("square on square", board_view,
                place_shape(pk_square, 16) | place_shape(pk_square, 18));
    for (int i = 0; i < 8; i++) begin
        rnd = $random(seed);
        k   = piece_kind_t'(3'($unsigned(rnd) % 7));
        drop_and_check(k);
        if (game_over) begin
            break;
        end
    end
    end_test("stacking", errs);
endtask

task automatic test_fall_pacing();
    int errs;
    bit exp_over;
    errs = error_count;
    apply_reset();
    model_drop(pk_line, exp_over);
    pulse_start(pk_line);
    repeat (3) @(negedge clk);
    // first tick is still ahead, piece sits at its spawn row
    check_board("line at first sample", board_view, place_shape(pk_line, 0));
    for (int n = 1; n <= 3; n++) begin
        repeat (tb_drop_ticks) @(negedge clk);
        check_board($sformatf("line after %0d intervals", n), board_view,
                    place_shape(pk_line, n));
    end
    wait_fall_end(pk_line, 1'b0);
    @(negedge clk);
    check_board("line at rest", board_view, model_board);
    end_test("fall pacing", errs);
endtask

task automatic test_dropped_starts();
    int errs;
    bit exp_over;
    errs = error_count;
    apply_reset();
    drop_and_check(pk_square);
    model_drop(pk_t, exp_over);
    pulse_start(pk_t);
    // line request while the T is still in flight
    pulse_start(pk_line);
    wait_fall_end(pk_t, 1'b0);
    @(negedge clk);
    check_board("T after start while busy", board_view, model_board);
    pulse_start(pk_none);
    repeat (tb_drop_ticks * 2) @(negedge clk);
    check_bit("busy after start with kind 7", busy, 1'b0);
    check_board("board after start with kind 7", board_view, model_board);
    end_test("dropped starts", errs);
endtask

task automatic test_game_over();
    int     errs;
    board_t exp_view;
    errs = error_count;
    apply_reset();
    for (int i = 0; i < 8; i++) begin
        drop_and_check(pk_line);
        if (game_over) begin
            break;
        end
    end
    check_bit("game_over after full column", game_over, 1'b1);
    // refused line stays drawn at the spawn row
    exp_view = model_board | place_shape(pk_line, 0);
    pulse_start(pk_square);
    repeat (tb_drop_ticks * 2) @(negedge clk);
    check_board("board after start in game over", board_view, exp_view);
    check_bit("game_over holds", game_over, 1'b1);
    check_bit("busy in game over", busy, 1'b0);
    check_bit("landed in game over", landed, 1'b0);
    end_test("game over", errs);
endtask

`endif

/* testbench/tb_tetris_fall.sv */
`timescale 1ns/1ps

module tb_tetris_fall
    import board_pkg::*;
    import piece_pkg::*;
();

    localparam int tb_drop_ticks = 4;
    // about 20 drops of 20 rows at 6 cycles each, with margin
    localparam int max_cycles = 6000;
    // longest single fall is 20 rows of tb_drop_ticks cycles plus a few
    localparam int land_limit = 200;

    logic        clk;
    logic        rst;
    logic        start;
    piece_kind_t piece_kind;
    board_t      board_view;
    logic        busy;
    logic        landed;
    logic        game_over;

    // settled cells as the reference model sees them
    board_t model_board;
    int     cycle_count = 0;
    int     error_count = 0;
    int     test_count = 0;
    int     failed_tests = 0;
    integer seed;

    tetris_fall_top #(
        .drop_ticks(tb_drop_ticks)
    ) tetris_fall_top_inst (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .piece_kind (piece_kind),
        .board_view (board_view),
        .busy       (busy),
        .landed     (landed),
        .game_over  (game_over)
    );

    `include "tb_checks.svh"

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        seed = 32'hde93;
        model_board = '0;
        rst        <= 1'b1;
        start      <= 1'b0;
        piece_kind <= pk_none;

        test_reset();
        test_single_drops();
        test_stacking();
        test_fall_pacing();
        test_dropped_starts();
        test_game_over();

        $display("tests run: %0d, tests with errors: %0d, errors: %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+testbench
rtl/board_pkg.sv
rtl/piece_pkg.sv
rtl/fall_if.sv
rtl/drop_timer.sv
rtl/fall_fsm.sv
rtl/piece_mover.sv
rtl/board_store.sv
rtl/tetris_fall_top.sv
testbench/tb_tetris_fall.sv

/* run_sim.sh */
#!/bin/sh
# build and run from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary -f project.f --top-module tb_tetris_fall -o sim_tetris_fall || exit 1
out=$(./obj_dir/sim_tetris_fall)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "All tests passed" \
    && echo "simulation ok" \
    || { echo "simulation reported failures"; exit 1; }
